/* e31x_pkg.sv */
package e31x_pkg;

  ////////////////////////////////////////////////////////////
  // Sample and channel word widths
  ////////////////////////////////////////////////////////////

  // One I or Q sample from the codec
  localparam int SAMPLE_W    = 12;
  // Zero bits below each sample in a channel word
  localparam int SAMPLE_PAD  = 4;
  localparam int CHAN_WORD_W = 32;

  ////////////////////////////////////////////////////////////
  // Daughterboard control words
  ////////////////////////////////////////////////////////////

  localparam int DB_GPIO_W = 32;
  // LED bits used per channel
  localparam int LED_W     = 3;

  ////////////////////////////////////////////////////////////
  // Status word and interrupt vector
  ////////////////////////////////////////////////////////////

  localparam int STATUS_W = 32;
  localparam int IRQ_W    = 16;

  // TCXO status nibble in bits 11:8
  // {PLL lock, 10 MHz present, PPS present, reference lock}
  localparam int ST_TCXO_LSB = 8;
  localparam int ST_TX_LOCK  = 7;
  localparam int ST_RX_LOCK  = 6;

  // Fabric to processor interrupt lines
  localparam int IRQ_BTN_PRESS   = 1;
  localparam int IRQ_BTN_RELEASE = 2;
  localparam int IRQ_PMU         = 3;

  // Depth of the bus_clk resynchronizers
  localparam int SYNC_STAGES = 2;

endpackage

/* button_irq.sv */
module button_irq #(
  parameter int STRETCH_LEN = 8
) (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic onswitch_db,
  output logic press_irq,
  output logic release_irq
);

  // Index 0 is the press path, index 1 the release path
  localparam int NUM_EDGES = 2;

  // Two most recent registered samples of the switch
  logic [1:0] onswitch_q;
  logic [NUM_EDGES-1:0] edge_det;
  logic [NUM_EDGES-1:0][STRETCH_LEN-1:0] edge_hist;

  ////////////////////////////////////////////////////////////
  // Edge detection
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      // Switch is active low, so start from the released level
      onswitch_q <= 2'b11;
    end else begin
      onswitch_q <= {onswitch_q[0], onswitch_db};
    end
  end

  // Press needs the new low level after two high samples
  assign edge_det[0] = ~onswitch_db & onswitch_q[0] & onswitch_q[1];
  // Release is the mirror case
  assign edge_det[1] = onswitch_db & ~onswitch_q[0] & ~onswitch_q[1];

  ////////////////////////////////////////////////////////////
  // Pulse stretching
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      edge_hist <= '0;
    end else begin
      for (int k = 0; k < NUM_EDGES; k++) begin
        edge_hist[k] <= (edge_hist[k] << 1) | STRETCH_LEN'(edge_det[k]);
      end
    end
  end

  // Long enough that the processor cannot miss the interrupt
  assign press_irq   = |edge_hist[0];
  assign release_irq = |edge_hist[1];

  // The two sample histories must never allow both edges at once
  assert property (@(posedge bus_clk) disable iff (bus_rst)
    !(edge_det[0] && edge_det[1]))
    else $error("button_irq: press and release detected together");

endmodule

/* board_status_sync.sv */
module board_status_sync (
  input  logic                            bus_clk,
  input  logic                            bus_rst,
  input  logic [3:0]                      tcxo_status,
  input  logic                            tx_pll_lock,
  input  logic                            rx_pll_lock,
  input  logic                            gps_pps,
  output logic [e31x_pkg::STATUS_W-1:0]   dboard_status,
  output logic                            pps_gpio
);

  // Four TCXO bits plus the two codec PLL locks
  localparam int NUM_ST = 6;

  // Bits of the status word that carry information
  localparam logic [e31x_pkg::STATUS_W-1:0] ST_USED =
      (e31x_pkg::STATUS_W'(4'hf) << e31x_pkg::ST_TCXO_LSB) |
      (e31x_pkg::STATUS_W'(1) << e31x_pkg::ST_TX_LOCK) |
      (e31x_pkg::STATUS_W'(1) << e31x_pkg::ST_RX_LOCK);

  logic [e31x_pkg::SYNC_STAGES-1:0][NUM_ST-1:0] st_sync;
  logic [NUM_ST-1:0] st_bus;
  logic [2:0] pps_q;

  ////////////////////////////////////////////////////////////
  // Status resynchronizers
  ////////////////////////////////////////////////////////////

  // Status comes from the TCXO and codec domains
  always_ff @(posedge bus_clk) begin
    st_sync[0] <= {tcxo_status, tx_pll_lock, rx_pll_lock};
    for (int s = 1; s < e31x_pkg::SYNC_STAGES; s++) begin
      st_sync[s] <= st_sync[s-1];
    end
  end

  assign st_bus = st_sync[e31x_pkg::SYNC_STAGES-1];

  // Daughterboard status word
  always_comb begin
    dboard_status = '0;
    dboard_status[e31x_pkg::ST_TCXO_LSB +: 4] = st_bus[5:2];
    dboard_status[e31x_pkg::ST_TX_LOCK] = st_bus[1];
    dboard_status[e31x_pkg::ST_RX_LOCK] = st_bus[0];
  end

  ////////////////////////////////////////////////////////////
  // PPS to processor GPIO
  ////////////////////////////////////////////////////////////

  // Lets the time daemon see the GPS pulse
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      pps_q <= '0;
    end else begin
      pps_q <= {pps_q[1:0], gps_pps};
    end
  end

  assign pps_gpio = pps_q[2];

  assert property (@(posedge bus_clk)
    (dboard_status & ~ST_USED) == '0)
    else $error("board_status_sync: reserved status bits set");

endmodule

/* sample_pack.sv */
module sample_pack (
  input  logic [e31x_pkg::SAMPLE_W-1:0]    rx_i0,
  input  logic [e31x_pkg::SAMPLE_W-1:0]    rx_q0,
  input  logic [e31x_pkg::SAMPLE_W-1:0]    rx_i1,
  input  logic [e31x_pkg::SAMPLE_W-1:0]    rx_q1,
  input  logic [e31x_pkg::CHAN_WORD_W-1:0] tx_chan0,
  input  logic [e31x_pkg::CHAN_WORD_W-1:0] tx_chan1,
  output logic [e31x_pkg::CHAN_WORD_W-1:0] rx_chan0,
  output logic [e31x_pkg::CHAN_WORD_W-1:0] rx_chan1,
  output logic [e31x_pkg::SAMPLE_W-1:0]    tx_i0,
  output logic [e31x_pkg::SAMPLE_W-1:0]    tx_q0,
  output logic [e31x_pkg::SAMPLE_W-1:0]    tx_i1,
  output logic [e31x_pkg::SAMPLE_W-1:0]    tx_q1
);

  // Top field of a channel word holds I
  localparam int I_MSB = e31x_pkg::CHAN_WORD_W - 1;
  // Q sits just above the low pad
  localparam int Q_LSB = e31x_pkg::SAMPLE_PAD;

  // I, pad, Q, pad from the top down
  function automatic logic [e31x_pkg::CHAN_WORD_W-1:0] pack_iq(
    input logic [e31x_pkg::SAMPLE_W-1:0] i_smp,
    input logic [e31x_pkg::SAMPLE_W-1:0] q_smp
  );
    return {i_smp, {e31x_pkg::SAMPLE_PAD{1'b0}},
            q_smp, {e31x_pkg::SAMPLE_PAD{1'b0}}};
  endfunction

  ////////////////////////////////////////////////////////////
  // Receive direction
  ////////////////////////////////////////////////////////////

  // Codec lanes are swapped relative to the radio channels
  assign rx_chan0 = pack_iq(rx_i1, rx_q1);
  assign rx_chan1 = pack_iq(rx_i0, rx_q0);

  ////////////////////////////////////////////////////////////
  // Transmit direction
  ////////////////////////////////////////////////////////////

  // Same swap on the way out, pad bits dropped
  assign tx_i1 = tx_chan0[I_MSB -: e31x_pkg::SAMPLE_W];
  assign tx_q1 = tx_chan0[Q_LSB +: e31x_pkg::SAMPLE_W];

  assign tx_i0 = tx_chan1[I_MSB -: e31x_pkg::SAMPLE_W];
  assign tx_q0 = tx_chan1[Q_LSB +: e31x_pkg::SAMPLE_W];

endmodule

/* frontend_ctrl.sv */
module frontend_ctrl (
  input  logic                           bus_clk,
  input  logic                           bus_rst,
  input  logic [e31x_pkg::DB_GPIO_W-1:0] gpio_out0,
  input  logic [e31x_pkg::DB_GPIO_W-1:0] gpio_ddr0,
  input  logic [e31x_pkg::DB_GPIO_W-1:0] gpio_out1,
  input  logic [e31x_pkg::DB_GPIO_W-1:0] gpio_ddr1,
  input  logic [e31x_pkg::LED_W-1:0]     leds0,
  input  logic [e31x_pkg::LED_W-1:0]     leds1,
  output logic [2:0]                     tx_bandsel,
  output logic [2:0]                     rx1_bandsel,
  output logic [2:0]                     rx2_bandsel,
  output logic [1:0]                     rx1b_bandsel,
  output logic [1:0]                     rx1c_bandsel,
  output logic [1:0]                     rx2b_bandsel,
  output logic [1:0]                     rx2c_bandsel,
  output logic                           tx_enable1a,
  output logic                           tx_enable1b,
  output logic                           tx_enable2a,
  output logic                           tx_enable2b,
  output logic                           vctxrx1_v1,
  output logic                           vctxrx1_v2,
  output logic                           vcrx1_v1,
  output logic                           vcrx1_v2,
  output logic                           vctxrx2_v1,
  output logic                           vctxrx2_v2,
  output logic                           vcrx2_v1,
  output logic                           vcrx2_v2,
  output logic                           led_txrx1_tx,
  output logic                           led_txrx1_rx,
  output logic                           led_rx1_rx,
  output logic                           led_txrx2_tx,
  output logic                           led_txrx2_rx,
  output logic                           led_rx2_rx
);

  // Only the low 16 GPIO bits reach front-end pins
  localparam int PIN_W = 16;

  logic [1:0][PIN_W-1:0] pins_q;
  logic [1:0][e31x_pkg::LED_W-1:0] led_q;

  // Undriven directions keep their pin low
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      pins_q <= '0;
      led_q  <= '0;
    end else begin
      pins_q[0] <= gpio_out0[PIN_W-1:0] & gpio_ddr0[PIN_W-1:0];
      pins_q[1] <= gpio_out1[PIN_W-1:0] & gpio_ddr1[PIN_W-1:0];
      led_q[0]  <= leds0;
      led_q[1]  <= leds1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pin fields, channel 1 on set 1 and channel 0 on set 2
  ////////////////////////////////////////////////////////////

  // Both channels share one TX filter bank
  assign tx_bandsel = pins_q[1][2:0] | pins_q[0][2:0];

  assign {vcrx1_v1, vcrx1_v2, vctxrx1_v1, vctxrx1_v2} = pins_q[1][15:12];
  assign {tx_enable1b, tx_enable1a} = pins_q[1][11:10];
  assign rx1c_bandsel = pins_q[1][9:8];
  assign rx1b_bandsel = pins_q[1][7:6];
  assign rx1_bandsel  = pins_q[1][5:3];

  assign {vcrx2_v1, vcrx2_v2, vctxrx2_v1, vctxrx2_v2} = pins_q[0][15:12];
  assign {tx_enable2b, tx_enable2a} = pins_q[0][11:10];
  assign rx2c_bandsel = pins_q[0][9:8];
  assign rx2b_bandsel = pins_q[0][7:6];
  assign rx2_bandsel  = pins_q[0][5:3];

  // LEDs
  assign {led_rx1_rx, led_txrx1_tx, led_txrx1_rx} = led_q[1];
  assign {led_rx2_rx, led_txrx2_tx, led_txrx2_rx} = led_q[0];

  assert property (@(posedge bus_clk) disable iff (bus_rst)
    (pins_q[0] & ~$past(gpio_ddr0[PIN_W-1:0])) == '0)
    else $error("frontend_ctrl: channel 0 pin high with input direction");

  assert property (@(posedge bus_clk) disable iff (bus_rst)
    (pins_q[1] & ~$past(gpio_ddr1[PIN_W-1:0])) == '0)
    else $error("frontend_ctrl: channel 1 pin high with input direction");

endmodule

/* e31x_glue.sv */
module e31x_glue #(
  parameter int STRETCH_LEN = 8
) (
  input  logic                             bus_clk,
  input  logic                             bus_rst,
  // Power button and interrupts
  input  logic                             onswitch_db,
  input  logic                             pmu_irq,
  output logic                             press_irq,
  output logic                             release_irq,
  output logic [e31x_pkg::IRQ_W-1:0]       irq_f2p,
  // Reference and codec status
  input  logic [3:0]                       tcxo_status,
  input  logic                             tx_pll_lock,
  input  logic                             rx_pll_lock,
  input  logic                             gps_pps,
  output logic [e31x_pkg::STATUS_W-1:0]    dboard_status,
  output logic                             pps_gpio,
  // Codec lanes and channel words
  input  logic [e31x_pkg::SAMPLE_W-1:0]    rx_i0,
  input  logic [e31x_pkg::SAMPLE_W-1:0]    rx_q0,
  input  logic [e31x_pkg::SAMPLE_W-1:0]    rx_i1,
  input  logic [e31x_pkg::SAMPLE_W-1:0]    rx_q1,
  input  logic [e31x_pkg::CHAN_WORD_W-1:0] tx_chan0,
  input  logic [e31x_pkg::CHAN_WORD_W-1:0] tx_chan1,
  output logic [e31x_pkg::CHAN_WORD_W-1:0] rx_chan0,
  output logic [e31x_pkg::CHAN_WORD_W-1:0] rx_chan1,
  output logic [e31x_pkg::SAMPLE_W-1:0]    tx_i0,
  output logic [e31x_pkg::SAMPLE_W-1:0]    tx_q0,
  output logic [e31x_pkg::SAMPLE_W-1:0]    tx_i1,
  output logic [e31x_pkg::SAMPLE_W-1:0]    tx_q1,
  // Daughterboard GPIO and LEDs
  input  logic [e31x_pkg::DB_GPIO_W-1:0]   gpio_out0,
  input  logic [e31x_pkg::DB_GPIO_W-1:0]   gpio_ddr0,
  input  logic [e31x_pkg::DB_GPIO_W-1:0]   gpio_out1,
  input  logic [e31x_pkg::DB_GPIO_W-1:0]   gpio_ddr1,
  input  logic [e31x_pkg::LED_W-1:0]       leds0,
  input  logic [e31x_pkg::LED_W-1:0]       leds1,
  // Front-end pins
  output logic [2:0]                       tx_bandsel,
  output logic [2:0]                       rx1_bandsel,
  output logic [2:0]                       rx2_bandsel,
  output logic [1:0]                       rx1b_bandsel,
  output logic [1:0]                       rx1c_bandsel,
  output logic [1:0]                       rx2b_bandsel,
  output logic [1:0]                       rx2c_bandsel,
  output logic                             tx_enable1a,
  output logic                             tx_enable1b,
  output logic                             tx_enable2a,
  output logic                             tx_enable2b,
  output logic                             vctxrx1_v1,
  output logic                             vctxrx1_v2,
  output logic                             vcrx1_v1,
  output logic                             vcrx1_v2,
  output logic                             vctxrx2_v1,
  output logic                             vctxrx2_v2,
  output logic                             vcrx2_v1,
  output logic                             vcrx2_v2,
  output logic                             led_txrx1_tx,
  output logic                             led_txrx1_rx,
  output logic                             led_rx1_rx,
  output logic                             led_txrx2_tx,
  output logic                             led_txrx2_rx,
  output logic                             led_rx2_rx
);

  ////////////////////////////////////////////////////////////
  // Power button and fabric to processor interrupts
  ////////////////////////////////////////////////////////////

  button_irq #(
    .STRETCH_LEN(STRETCH_LEN)
  ) button_irq_i (
    .bus_clk(bus_clk),
    .bus_rst(bus_rst),
    .onswitch_db(onswitch_db),
    .press_irq(press_irq),
    .release_irq(release_irq)
  );

  // PMU interrupt passes straight through
  always_comb begin
    irq_f2p = '0;
    irq_f2p[e31x_pkg::IRQ_BTN_PRESS]   = press_irq;
    irq_f2p[e31x_pkg::IRQ_BTN_RELEASE] = release_irq;
    irq_f2p[e31x_pkg::IRQ_PMU]         = pmu_irq;
  end

  ////////////////////////////////////////////////////////////
  // Status, samples and front end
  ////////////////////////////////////////////////////////////

  board_status_sync board_status_sync_i (
    .bus_clk(bus_clk),
    .bus_rst(bus_rst),
    .tcxo_status(tcxo_status),
    .tx_pll_lock(tx_pll_lock),
    .rx_pll_lock(rx_pll_lock),
    .gps_pps(gps_pps),
    .dboard_status(dboard_status),
    .pps_gpio(pps_gpio)
  );

  sample_pack sample_pack_i (
    .rx_i0(rx_i0), .rx_q0(rx_q0), .rx_i1(rx_i1), .rx_q1(rx_q1),
    .tx_chan0(tx_chan0), .tx_chan1(tx_chan1),
    .rx_chan0(rx_chan0), .rx_chan1(rx_chan1),
    .tx_i0(tx_i0), .tx_q0(tx_q0), .tx_i1(tx_i1), .tx_q1(tx_q1)
  );

  frontend_ctrl frontend_ctrl_i (
    .bus_clk(bus_clk), .bus_rst(bus_rst),
    .gpio_out0(gpio_out0), .gpio_ddr0(gpio_ddr0),
    .gpio_out1(gpio_out1), .gpio_ddr1(gpio_ddr1),
    .leds0(leds0), .leds1(leds1),
    .tx_bandsel(tx_bandsel),
    .rx1_bandsel(rx1_bandsel), .rx2_bandsel(rx2_bandsel),
    .rx1b_bandsel(rx1b_bandsel), .rx1c_bandsel(rx1c_bandsel),
    .rx2b_bandsel(rx2b_bandsel), .rx2c_bandsel(rx2c_bandsel),
    .tx_enable1a(tx_enable1a), .tx_enable1b(tx_enable1b),
    .tx_enable2a(tx_enable2a), .tx_enable2b(tx_enable2b),
    .vctxrx1_v1(vctxrx1_v1), .vctxrx1_v2(vctxrx1_v2),
    .vcrx1_v1(vcrx1_v1), .vcrx1_v2(vcrx1_v2),
    .vctxrx2_v1(vctxrx2_v1), .vctxrx2_v2(vctxrx2_v2),
    .vcrx2_v1(vcrx2_v1), .vcrx2_v2(vcrx2_v2),
    .led_txrx1_tx(led_txrx1_tx), .led_txrx1_rx(led_txrx1_rx),
    .led_rx1_rx(led_rx1_rx),
    .led_txrx2_tx(led_txrx2_tx), .led_txrx2_rx(led_txrx2_rx),
    .led_rx2_rx(led_rx2_rx)
  );

endmodule

/* glue_checker.sv */
module glue_checker #(
  parameter int STRETCH_LEN = 8
) (
  input  logic                               bus_clk,
  input  logic                               bus_rst,
  input  logic                               onswitch_db,
  input  logic                               pmu_irq,
  input  logic                               press_irq,
  input  logic                               release_irq,
  input  logic [e31x_pkg::IRQ_W-1:0]         irq_f2p,
  input  logic [3:0]                         tcxo_status,
  input  logic                               tx_pll_lock,
  input  logic                               rx_pll_lock,
  input  logic                               gps_pps,
  input  logic [e31x_pkg::STATUS_W-1:0]      dboard_status,
  input  logic                               pps_gpio,
  // Codec lanes as {i0, q0, i1, q1}
  input  logic [4*e31x_pkg::SAMPLE_W-1:0]    rx_lanes,
  input  logic [4*e31x_pkg::SAMPLE_W-1:0]    tx_lanes,
  input  logic [e31x_pkg::CHAN_WORD_W-1:0]   tx_chan0,
  input  logic [e31x_pkg::CHAN_WORD_W-1:0]   tx_chan1,
  input  logic [e31x_pkg::CHAN_WORD_W-1:0]   rx_chan0,
  input  logic [e31x_pkg::CHAN_WORD_W-1:0]   rx_chan1,
  input  logic [e31x_pkg::DB_GPIO_W-1:0]     gpio_out0,
  input  logic [e31x_pkg::DB_GPIO_W-1:0]     gpio_ddr0,
  input  logic [e31x_pkg::DB_GPIO_W-1:0]     gpio_out1,
  input  logic [e31x_pkg::DB_GPIO_W-1:0]     gpio_ddr1,
  input  logic [e31x_pkg::LED_W-1:0]         leds0,
  input  logic [e31x_pkg::LED_W-1:0]         leds1,
  // Front-end pins in the port order of the top level
  input  logic [34:0]                        fe_pins,
  output int                                 check_count,
  output int                                 error_count
);
  timeunit 1ns;
  timeprecision 100ps;

  // Reference state, advanced once per rising edge
  logic [5:0] st_h1, st_h2;
  int st_edges;
  logic armed;
  logic [1:0] sw_h;
  int press_left, release_left;
  logic [2:0] pps_m;
  logic [34:0] fe_exp;
  logic [e31x_pkg::IRQ_W-1:0] irq_exp;

  initial begin
    check_count = 0;
    error_count = 0;
    st_edges = 0;
    armed = 1'b0;
  end

  task automatic compare_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference functions
  ////////////////////////////////////////////////////////////

  // I in the top 12 bits, Q just above the low 4 pad bits
  function automatic logic [31:0] pack_ref(input logic [11:0] i_smp, input logic [11:0] q_smp);
    return ({20'd0, i_smp} << 20) | ({20'd0, q_smp} << 4);
  endfunction

  function automatic logic [23:0] unpack_ref(input logic [31:0] chan);
    return {chan[31:20], chan[15:4]};
  endfunction

  // st is {tcxo[3:0], tx lock, rx lock}
  function automatic logic [31:0] status_ref(input logic [5:0] st);
    return (32'(st[5:2]) << e31x_pkg::ST_TCXO_LSB) |
           (32'(st[1]) << e31x_pkg::ST_TX_LOCK) |
           (32'(st[0]) << e31x_pkg::ST_RX_LOCK);
  endfunction

  function automatic logic [34:0] fe_ref(input logic [31:0] o0, d0, o1, d1,
                                         input logic [2:0] l0, l1);
    logic [15:0] c0;
    logic [15:0] c1;
    c0 = o0[15:0] & d0[15:0];
    c1 = o1[15:0] & d1[15:0];
    // Channel 1 feeds the "1" pins, channel 0 the "2" pins
    return {c1[2:0] | c0[2:0], c1[5:3], c0[5:3],
            c1[7:6], c1[9:8], c0[7:6], c0[9:8],
            c1[10], c1[11], c0[10], c0[11],
            c1[13], c1[12], c1[15], c1[14], c0[13], c0[12], c0[15], c0[14],
            l1[1], l1[0], l1[2], l0[1], l0[0], l0[2]};
  endfunction

  ////////////////////////////////////////////////////////////
  // Comparison at every rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge bus_clk) begin
    // Sample paths follow the inputs of this cycle
    compare_value("rx_chan0", 64'(rx_chan0), 64'(pack_ref(rx_lanes[23:12], rx_lanes[11:0])));
    compare_value("rx_chan1", 64'(rx_chan1), 64'(pack_ref(rx_lanes[47:36], rx_lanes[35:24])));
    compare_value("tx lanes", 64'(tx_lanes), 64'({unpack_ref(tx_chan1), unpack_ref(tx_chan0)}));
    if (st_edges >= e31x_pkg::SYNC_STAGES) begin
      compare_value("dboard_status", 64'(dboard_status), 64'(status_ref(st_h2)));
    end
    if (armed) begin
      irq_exp = '0;
      irq_exp[e31x_pkg::IRQ_BTN_PRESS] = (press_left > 0);
      irq_exp[e31x_pkg::IRQ_BTN_RELEASE] = (release_left > 0);
      irq_exp[e31x_pkg::IRQ_PMU] = pmu_irq;
      compare_value("irq_f2p", 64'(irq_f2p), 64'(irq_exp));
      compare_value("press_irq", 64'(press_irq), 64'(press_left > 0));
      compare_value("release_irq", 64'(release_irq), 64'(release_left > 0));
      compare_value("pps_gpio", 64'(pps_gpio), 64'(pps_m[2]));
      compare_value("front-end pins", 64'(fe_pins), 64'(fe_exp));
    end

    // Advance the reference past this edge
    st_h2 = st_h1;
    st_h1 = {tcxo_status, tx_pll_lock, rx_pll_lock};
    st_edges++;
    if (bus_rst) begin
      armed = 1'b1;
      sw_h = 2'b11;
      press_left = 0;
      release_left = 0;
      pps_m = '0;
      fe_exp = '0;
    end else begin
      if (!onswitch_db && sw_h == 2'b11) begin
        press_left = STRETCH_LEN;
      end else if (press_left > 0) begin
        press_left--;
      end
      if (onswitch_db && sw_h == 2'b00) begin
        release_left = STRETCH_LEN;
      end else if (release_left > 0) begin
        release_left--;
      end
      sw_h = {sw_h[0], onswitch_db};
      pps_m = {pps_m[1:0], gps_pps};
      fe_exp = fe_ref(gpio_out0, gpio_ddr0, gpio_out1, gpio_ddr1, leds0, leds1);
    end
  end

endmodule

/* tb_e31x_glue.sv */
module tb_e31x_glue;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int STRETCH_LEN = 8;
  localparam int NUM_RAND = 200;
  localparam int STATUS_ROUNDS = 150;
  // Stimulus runs about 900 cycles, so this is roughly twice that
  localparam int MAX_CYCLES = 2000;

  logic bus_clk = 1'b0;
  logic bus_rst;
  logic onswitch_db, pmu_irq, press_irq, release_irq;
  logic [e31x_pkg::IRQ_W-1:0] irq_f2p;
  logic [3:0] tcxo_status;
  logic tx_pll_lock, rx_pll_lock, gps_pps, pps_gpio;
  logic [e31x_pkg::STATUS_W-1:0] dboard_status;
  logic [e31x_pkg::SAMPLE_W-1:0] rx_i0, rx_q0, rx_i1, rx_q1;
  logic [e31x_pkg::SAMPLE_W-1:0] tx_i0, tx_q0, tx_i1, tx_q1;
  logic [e31x_pkg::CHAN_WORD_W-1:0] tx_chan0, tx_chan1, rx_chan0, rx_chan1;
  logic [e31x_pkg::DB_GPIO_W-1:0] gpio_out0, gpio_ddr0, gpio_out1, gpio_ddr1;
  logic [e31x_pkg::LED_W-1:0] leds0, leds1;
  logic [2:0] tx_bandsel, rx1_bandsel, rx2_bandsel;
  logic [1:0] rx1b_bandsel, rx1c_bandsel, rx2b_bandsel, rx2c_bandsel;
  logic tx_enable1a, tx_enable1b, tx_enable2a, tx_enable2b;
  logic vctxrx1_v1, vctxrx1_v2, vcrx1_v1, vcrx1_v2;
  logic vctxrx2_v1, vctxrx2_v2, vcrx2_v1, vcrx2_v2;
  logic led_txrx1_tx, led_txrx1_rx, led_rx1_rx;
  logic led_txrx2_tx, led_txrx2_rx, led_rx2_rx;
  int check_count, error_count;
  int cycle_count = 0;

  always #2 bus_clk = ~bus_clk;

  e31x_glue #(
    .STRETCH_LEN(STRETCH_LEN)
  ) DUT (
    .*
  );

  glue_checker #(
    .STRETCH_LEN(STRETCH_LEN)
  ) glue_checker_i (
    .bus_clk, .bus_rst, .onswitch_db, .pmu_irq, .press_irq, .release_irq, .irq_f2p,
    .tcxo_status, .tx_pll_lock, .rx_pll_lock, .gps_pps, .dboard_status, .pps_gpio,
    .rx_lanes({rx_i0, rx_q0, rx_i1, rx_q1}),
    .tx_lanes({tx_i0, tx_q0, tx_i1, tx_q1}),
    .tx_chan0, .tx_chan1, .rx_chan0, .rx_chan1,
    .gpio_out0, .gpio_ddr0, .gpio_out1, .gpio_ddr1, .leds0, .leds1,
    .fe_pins({tx_bandsel, rx1_bandsel, rx2_bandsel,
              rx1b_bandsel, rx1c_bandsel, rx2b_bandsel, rx2c_bandsel,
              tx_enable1a, tx_enable1b, tx_enable2a, tx_enable2b,
              vctxrx1_v1, vctxrx1_v2, vcrx1_v1, vcrx1_v2,
              vctxrx2_v1, vctxrx2_v2, vcrx2_v1, vcrx2_v2,
              led_txrx1_tx, led_txrx1_rx, led_rx1_rx,
              led_txrx2_tx, led_txrx2_rx, led_rx2_rx}),
    .check_count, .error_count
  );

  ////////////////////////////////////////////////////////////
  // Stimulus, driven on the falling edge
  ////////////////////////////////////////////////////////////

  // Switch is active low, 20 cycles pressed then 20 released
  task automatic press_and_release();
    for (int n = 0; n < 40; n++) begin
      @(negedge bus_clk);
      onswitch_db = (n >= 20);
      pmu_irq = 1'($urandom());
    end
    @(negedge bus_clk);
    pmu_irq = 1'b0;
  endtask

  // Each value held for 3 cycles
  task automatic drive_status(input int rounds);
    repeat (rounds) begin
      @(negedge bus_clk);
      tcxo_status = 4'($urandom());
      {tx_pll_lock, rx_pll_lock, gps_pps} = 3'($urandom());
      repeat (2) @(negedge bus_clk);
    end
  endtask

  task automatic drive_samples();
    repeat (NUM_RAND) begin
      @(negedge bus_clk);
      {rx_i0, rx_q0, rx_i1, rx_q1} = {$urandom(), 16'($urandom())};
      tx_chan0 = $urandom();
      tx_chan1 = $urandom();
    end
  endtask

  task automatic drive_frontend();
    repeat (NUM_RAND) begin
      @(negedge bus_clk);
      gpio_out0 = $urandom();
      gpio_ddr0 = $urandom();
      gpio_out1 = $urandom();
      gpio_ddr1 = $urandom();
      {leds0, leds1} = 6'($urandom());
    end
  endtask

  initial begin
    void'($urandom(32'h6193546c));
    bus_rst = 1'b1;
    // Active inputs while in reset, the registered outputs stay low
    onswitch_db = 1'b0;
    pmu_irq = 1'b0;
    tcxo_status = '0;
    {tx_pll_lock, rx_pll_lock} = '0;
    gps_pps = 1'b1;
    {rx_i0, rx_q0, rx_i1, rx_q1} = '0;
    {tx_chan0, tx_chan1} = '0;
    {gpio_out0, gpio_ddr0, gpio_out1, gpio_ddr1} = '1;
    {leds0, leds1} = '1;
    repeat (4) @(posedge bus_clk);
    @(negedge bus_clk);
    bus_rst = 1'b0;
    onswitch_db = 1'b1;
    gps_pps = 1'b0;
    {gpio_out0, gpio_ddr0, gpio_out1, gpio_ddr1} = '0;
    {leds0, leds1} = '0;
    repeat (2) @(negedge bus_clk);

    press_and_release();
    drive_status(STATUS_ROUNDS);
    drive_samples();
    drive_frontend();

    // Let the registered paths drain
    repeat (4) @(negedge bus_clk);
    $display("Run complete: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  always @(posedge bus_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

endmodule

/* filelist.f */
e31x_pkg.sv
button_irq.sv
board_status_sync.sv
sample_pack.sv
frontend_ctrl.sv
e31x_glue.sv
glue_checker.sv
tb_e31x_glue.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the e31x glue testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_e31x_glue -o sim_e31x_glue
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_e31x_glue > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
